/* logic/brisc_pkg.sv */
package brisc_pkg;

  parameter int xlen     = 32;
  parameter int reg_bits = 5;

  typedef logic [xlen-1:0]     word_t;
  typedef logic [reg_bits-1:0] reg_idx_t;

  // Enum literals share the package scope, hence the prefixes
  typedef enum logic [1:0] {
    fwd_from_rf,
    fwd_from_cache,
    fwd_from_wb
  } fwd_src_e;

  typedef enum logic {
    from_rs1,
    from_pc
  } alu_src1_e;

  typedef enum logic {
    from_rs2,
    from_imm
  } alu_src2_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b
  } alu_ctrl_e;

  typedef enum logic [2:0] {
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu
  } branch_cond_e;

  typedef enum logic [1:0] {
    res_from_alu,
    res_from_cache,
    res_from_pc4
  } result_src_e;

  typedef enum logic [1:0] {
    size_b,
    size_h,
    size_w
  } data_size_e;

  typedef enum logic [1:0] {
    no_xcpt,
    mem_unaligned,
    addr_invalid
  } xcpt_e;

  // Decoded instruction as presented by decode
  typedef struct packed {
    logic         valid;
    word_t        pc;
    word_t        rs1_data;
    word_t        rs2_data;
    word_t        imm;
    reg_idx_t     rd;
    alu_src1_e    alu_src1;
    alu_src2_e    alu_src2;
    alu_ctrl_e    alu_ctrl;
    logic         is_branch;
    branch_cond_e branch_cond;
    logic         is_jump;
    logic         reg_write;
    result_src_e  result_src;
    logic         mem_write;
    data_size_e   data_size;
  } issue_t;

  // Selected operands of the instruction sitting in execute
  typedef struct packed {
    logic         valid;
    word_t        src_a;
    word_t        src_b;
    word_t        cmp_a;
    word_t        cmp_b;
    word_t        store_data;
    word_t        pc;
    word_t        imm;
    reg_idx_t     rd;
    alu_ctrl_e    alu_ctrl;
    logic         is_branch;
    branch_cond_e branch_cond;
    logic         is_jump;
    logic         reg_write;
    result_src_e  result_src;
    logic         mem_write;
    data_size_e   data_size;
  } operands_t;

  // Execute to memory
  typedef struct packed {
    logic        valid;
    word_t       alu_res;
    word_t       pc_plus4;
    word_t       store_data;
    reg_idx_t    rd;
    logic        reg_write;
    result_src_e result_src;
    logic        mem_write;
    data_size_e  data_size;
    logic        pc_src;
    word_t       pc_target;
    xcpt_e       xcpt;
  } exec_out_t;

endpackage

/* logic/ex_issue_reg.sv */
`timescale 1ns/1ps

module ex_issue_reg (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stall,
  input  logic                 flush,
  input  brisc_pkg::issue_t    issue,
  input  brisc_pkg::fwd_src_e  fwd_sel_a,
  input  brisc_pkg::fwd_src_e  fwd_sel_b,
  input  brisc_pkg::word_t     alu_res_cache,
  input  brisc_pkg::word_t     result_wb,
  output brisc_pkg::operands_t operands
);

  brisc_pkg::issue_t issue_q;
  brisc_pkg::word_t  rs1_fwd;
  brisc_pkg::word_t  rs2_fwd;

  // Flush wins over stall
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_q <= '0;
    end else if (flush) begin
      issue_q <= '0;
    end else if (!stall) begin
      issue_q <= issue;
    end
  end

  // Bypass from cache and write-back stages
  always_comb begin
    case (fwd_sel_a)
      brisc_pkg::fwd_from_cache: rs1_fwd = alu_res_cache;
      brisc_pkg::fwd_from_wb:    rs1_fwd = result_wb;
      default:                   rs1_fwd = issue_q.rs1_data;
    endcase

    case (fwd_sel_b)
      brisc_pkg::fwd_from_cache: rs2_fwd = alu_res_cache;
      brisc_pkg::fwd_from_wb:    rs2_fwd = result_wb;
      default:                   rs2_fwd = issue_q.rs2_data;
    endcase
  end

  always_comb begin
    operands.valid       = issue_q.valid;
    // PC select applies after forwarding
    operands.src_a       = (issue_q.alu_src1 == brisc_pkg::from_pc) ? issue_q.pc : rs1_fwd;
    operands.src_b       = (issue_q.alu_src2 == brisc_pkg::from_imm) ? issue_q.imm : rs2_fwd;
    operands.cmp_a       = rs1_fwd;
    operands.cmp_b       = rs2_fwd;
    operands.store_data  = rs2_fwd;
    operands.pc          = issue_q.pc;
    operands.imm         = issue_q.imm;
    operands.rd          = issue_q.rd;
    operands.alu_ctrl    = issue_q.alu_ctrl;
    operands.is_branch   = issue_q.is_branch;
    operands.branch_cond = issue_q.branch_cond;
    operands.is_jump     = issue_q.is_jump;
    operands.reg_write   = issue_q.reg_write;
    operands.result_src  = issue_q.result_src;
    operands.mem_write   = issue_q.mem_write;
    operands.data_size   = issue_q.data_size;
  end

  flush_makes_bubble: assert property (
    @(posedge clk) disable iff (!arst_n)
    flush |=> !issue_q.valid
  ) else $error("issue register still valid after flush");

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
  input  brisc_pkg::word_t     src_a,
  input  brisc_pkg::word_t     src_b,
  input  brisc_pkg::alu_ctrl_e ctrl,
  output brisc_pkg::word_t     result,
  output logic                 zero
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = src_b[4:0];
  assign lt_signed   = $signed(src_a) < $signed(src_b);
  assign lt_unsigned = src_a < src_b;

  always_comb begin
    case (ctrl)
      brisc_pkg::alu_add: begin
        result = src_a + src_b;
      end
      brisc_pkg::alu_sub: begin
        result = src_a - src_b;
      end
      brisc_pkg::alu_and: begin
        result = src_a & src_b;
      end
      brisc_pkg::alu_or: begin
        result = src_a | src_b;
      end
      brisc_pkg::alu_xor: begin
        result = src_a ^ src_b;
      end
      brisc_pkg::alu_sll: begin
        result = src_a << shamt;
      end
      brisc_pkg::alu_srl: begin
        result = src_a >> shamt;
      end
      // Sign fill from bit 31
      brisc_pkg::alu_sra: begin
        result = $signed(src_a) >>> shamt;
      end
      brisc_pkg::alu_slt: begin
        result = {{(brisc_pkg::xlen-1){1'b0}}, lt_signed};
      end
      brisc_pkg::alu_sltu: begin
        result = {{(brisc_pkg::xlen-1){1'b0}}, lt_unsigned};
      end
      brisc_pkg::alu_pass_b: begin
        result = src_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

/* logic/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
  input  brisc_pkg::operands_t operands,
  output logic                 taken,
  output brisc_pkg::word_t     target
);

  logic cond_met;
  logic eq;
  logic lt_s;
  logic lt_u;

  // Compares forwarded register values, not the ALU inputs
  assign eq   = (operands.cmp_a == operands.cmp_b);
  assign lt_s = $signed(operands.cmp_a) < $signed(operands.cmp_b);
  assign lt_u = operands.cmp_a < operands.cmp_b;

  always_comb begin
    case (operands.branch_cond)
      brisc_pkg::beq: begin
        cond_met = eq;
      end
      brisc_pkg::bne: begin
        cond_met = !eq;
      end
      brisc_pkg::blt: begin
        cond_met = lt_s;
      end
      brisc_pkg::bge: begin
        cond_met = !lt_s;
      end
      brisc_pkg::bltu: begin
        cond_met = lt_u;
      end
      brisc_pkg::bgeu: begin
        cond_met = !lt_u;
      end
      default: begin
        cond_met = 1'b0;
      end
    endcase
  end

  assign taken  = operands.valid && ((operands.is_branch && cond_met) || operands.is_jump);
  assign target = operands.pc + operands.imm;

endmodule

/* logic/ex_commit.sv */
`timescale 1ns/1ps

module ex_commit #(
  parameter brisc_pkg::word_t data_base = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stall,
  input  brisc_pkg::operands_t operands,
  input  brisc_pkg::word_t     alu_res,
  input  logic                 zero,
  input  logic                 taken,
  input  brisc_pkg::word_t     target,
  output brisc_pkg::exec_out_t ex_out
);

  brisc_pkg::exec_out_t ex_next;
  brisc_pkg::xcpt_e     xcpt;
  logic                 is_mem;
  logic                 misaligned;

  // Loads are recognised by their result source
  assign is_mem = operands.valid &&
                  (operands.mem_write || operands.result_src == brisc_pkg::res_from_cache);

  always_comb begin
    case (operands.data_size)
      brisc_pkg::size_w: misaligned = (alu_res[1:0] != 2'b00);
      brisc_pkg::size_h: misaligned = alu_res[0];
      default:           misaligned = 1'b0;
    endcase

    xcpt = brisc_pkg::no_xcpt;
    if (is_mem) begin
      if (misaligned) begin
        xcpt = brisc_pkg::mem_unaligned;
      end else if (alu_res < data_base) begin
        xcpt = brisc_pkg::addr_invalid;
      end
    end
  end

  always_comb begin
    ex_next.valid      = operands.valid;
    ex_next.alu_res    = alu_res;
    ex_next.pc_plus4   = operands.pc + 32'd4;
    ex_next.store_data = operands.store_data;
    ex_next.rd         = operands.rd;
    ex_next.reg_write  = operands.reg_write;
    ex_next.result_src = operands.result_src;
    ex_next.mem_write  = operands.mem_write;
    ex_next.data_size  = operands.data_size;
    ex_next.pc_src     = taken;
    ex_next.pc_target  = target;
    ex_next.xcpt       = xcpt;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_out <= '0;
    end else if (!stall) begin
      ex_out <= ex_next;
    end
  end

  no_redirect_on_bubble: assert property (
    @(posedge clk) disable iff (!arst_n)
    ex_out.pc_src |-> ex_out.valid
  ) else $error("pc_src high on a bubble");

  // Branch unit and ALU agree on beq when the ALU subtracts the same operands
  beq_matches_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    operands.valid && operands.is_branch && !operands.is_jump &&
    operands.branch_cond == brisc_pkg::beq && operands.alu_ctrl == brisc_pkg::alu_sub &&
    operands.src_a == operands.cmp_a && operands.src_b == operands.cmp_b
    |-> taken == zero
  ) else $error("beq outcome disagrees with ALU zero flag");

  legal_alu_ctrl: assert property (
    @(posedge clk) disable iff (!arst_n)
    operands.valid |-> operands.alu_ctrl inside {[brisc_pkg::alu_add:brisc_pkg::alu_pass_b]}
  ) else $error("undefined ALU operation on a valid instruction");

endmodule

/* logic/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage #(
  parameter brisc_pkg::word_t data_base = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stall,
  input  logic                 flush,
  input  brisc_pkg::issue_t    issue,
  input  brisc_pkg::fwd_src_e  fwd_sel_a,
  input  brisc_pkg::fwd_src_e  fwd_sel_b,
  input  brisc_pkg::word_t     alu_res_cache,
  input  brisc_pkg::word_t     result_wb,
  output brisc_pkg::exec_out_t ex_out
);

  brisc_pkg::operands_t operands;
  brisc_pkg::word_t     alu_res;
  logic                 zero;
  logic                 taken;
  brisc_pkg::word_t     target;

  // Decode to execute register with bypass
  ex_issue_reg u_issue (
    .clk           (clk),
    .arst_n        (arst_n),
    .stall         (stall),
    .flush         (flush),
    .issue         (issue),
    .fwd_sel_a     (fwd_sel_a),
    .fwd_sel_b     (fwd_sel_b),
    .alu_res_cache (alu_res_cache),
    .result_wb     (result_wb),
    .operands      (operands)
  );

  alu u_alu (
    .src_a  (operands.src_a),
    .src_b  (operands.src_b),
    .ctrl   (operands.alu_ctrl),
    .result (alu_res),
    .zero   (zero)
  );

  // Runs beside the ALU
  branch_unit u_branch (
    .operands (operands),
    .taken    (taken),
    .target   (target)
  );

  ex_commit #(
    .data_base (data_base)
  ) u_commit (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (stall),
    .operands (operands),
    .alu_res  (alu_res),
    .zero     (zero),
    .taken    (taken),
    .target   (target),
    .ex_out   (ex_out)
  );

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter real period       = 4.0,
  parameter int  reset_cycles = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

/* verif/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
  parameter int n_rows = 24
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stall,
  input  logic                 flush,
  input  brisc_pkg::exec_out_t ex_out,
  input  int                   row_idx,
  input  brisc_pkg::issue_t    issue,
  input  logic                 exp_valid,
  input  brisc_pkg::word_t     exp_alu_res,
  input  logic                 exp_pc_src,
  input  brisc_pkg::word_t     exp_pc_target,
  input  brisc_pkg::xcpt_e     exp_xcpt,
  input  brisc_pkg::word_t     exp_store_data,
  output logic                 done,
  output int                   n_pass,
  output int                   n_fail
);

  typedef struct packed {
    logic                   flushed;
    logic                   valid;
    brisc_pkg::word_t       alu_res;
    logic                   pc_src;
    brisc_pkg::word_t       pc_target;
    brisc_pkg::xcpt_e       xcpt;
    brisc_pkg::word_t       store_data;
    brisc_pkg::word_t       pc_plus4;
    brisc_pkg::reg_idx_t    rd;
    logic                   reg_write;
    brisc_pkg::result_src_e result_src;
    logic                   mem_write;
    brisc_pkg::data_size_e  data_size;
  } expect_t;

  // Slot 0 tracks the issue register, slot 1 the commit register
  expect_t              slot [2];
  int                   idx [2] = '{-1, -1};
  logic                 moved = 1'b0;
  logic                 held_check = 1'b0;
  brisc_pkg::exec_out_t held;
  int                   stall_row;
  int                   reported = 0;
  logic                 reset_reported = 1'b0;
  logic                 bad = 1'b0;

  initial begin
    done   = 1'b0;
    n_pass = 0;
    n_fail = 0;
  end

  task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] act);
    if (act !== expv) begin
      $display("CHECK FAILED ex_out.%s expected %h actual %h", name, expv, act);
      bad = 1'b1;
    end
  endtask

  task automatic end_test(input string what);
    if (bad) begin
      n_fail++;
      $display("%s: FAILED", what);
    end else begin
      n_pass++;
      $display("%s: ok", what);
    end
  endtask

  // Control fields travel unchanged from decode
  function automatic expect_t build_expect();
    expect_t e;
    e            = '0;
    e.valid      = exp_valid;
    e.alu_res    = exp_alu_res;
    e.pc_src     = exp_pc_src;
    e.pc_target  = exp_pc_target;
    e.xcpt       = exp_xcpt;
    e.store_data = exp_store_data;
    e.pc_plus4   = issue.pc + 4;
    e.rd         = issue.rd;
    e.reg_write  = issue.reg_write;
    e.result_src = issue.result_src;
    e.mem_write  = issue.mem_write;
    e.data_size  = issue.data_size;
    return e;
  endfunction

  task automatic check_reset();
    compare("valid", 0, ex_out.valid);
    compare("reg_write", 0, ex_out.reg_write);
    compare("mem_write", 0, ex_out.mem_write);
    compare("pc_src", 0, ex_out.pc_src);
    compare("xcpt", brisc_pkg::no_xcpt, ex_out.xcpt);
  endtask

  task automatic check_slot();
    expect_t e;
    e   = slot[1];
    bad = 1'b0;
    compare("valid", e.valid, ex_out.valid);
    compare("pc_src", e.pc_src, ex_out.pc_src);
    compare("xcpt", e.xcpt, ex_out.xcpt);
    if (e.flushed) begin
      compare("reg_write", 0, ex_out.reg_write);
      compare("mem_write", 0, ex_out.mem_write);
    end else begin
      compare("reg_write", e.reg_write, ex_out.reg_write);
      compare("mem_write", e.mem_write, ex_out.mem_write);
      compare("rd", e.rd, ex_out.rd);
      compare("result_src", e.result_src, ex_out.result_src);
      compare("data_size", e.data_size, ex_out.data_size);
      compare("pc_plus4", e.pc_plus4, ex_out.pc_plus4);
      if (e.valid) begin
        compare("alu_res", e.alu_res, ex_out.alu_res);
        compare("pc_target", e.pc_target, ex_out.pc_target);
        compare("store_data", e.store_data, ex_out.store_data);
      end
    end
    end_test($sformatf("row %0d%s", idx[1], e.flushed ? " (flushed)" : ""));
    reported++;
  endtask

  always @(posedge clk) begin
    moved      = 1'b0;
    held_check = 1'b0;
    if (arst_n) begin
      if (stall) begin
        held       = ex_out;
        held_check = 1'b1;
        stall_row  = row_idx;
      end else begin
        slot[1] = slot[0];
        idx[1]  = idx[0];
        moved   = 1'b1;
      end
      if (flush) begin
        slot[0]         = '0;
        slot[0].flushed = 1'b1;
        idx[0]          = row_idx;
      end else if (!stall) begin
        slot[0] = build_expect();
        idx[0]  = row_idx;
      end
    end
  end

  always @(negedge clk) begin
    if (!arst_n) begin
      check_reset();
    end else begin
      if (!reset_reported) begin
        check_reset();
        end_test("reset");
        reset_reported = 1'b1;
      end
      if (held_check) begin
        bad = 1'b0;
        if (ex_out !== held) begin
          $display("stalled row %0d: ex_out changed while stall was high", stall_row);
          bad = 1'b1;
        end
        end_test($sformatf("row %0d (stall)", stall_row));
        reported++;
      end
      if (moved && idx[1] >= 0) begin
        check_slot();
      end
      if (reported == n_rows) begin
        done = 1'b1;
      end
    end
  end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  localparam int n_rows     = 24;
  localparam int n_cols     = 26;
  localparam int max_cycles = n_rows * 3 + 20;

  logic                 clk;
  logic                 arst_n;
  logic                 stall;
  logic                 flush;
  brisc_pkg::issue_t    issue;
  brisc_pkg::fwd_src_e  fwd_sel_a;
  brisc_pkg::fwd_src_e  fwd_sel_b;
  brisc_pkg::word_t     alu_res_cache;
  brisc_pkg::word_t     result_wb;
  brisc_pkg::exec_out_t ex_out;

  int                   row_idx;
  logic                 exp_valid;
  brisc_pkg::word_t     exp_alu_res;
  logic                 exp_pc_src;
  brisc_pkg::word_t     exp_pc_target;
  brisc_pkg::xcpt_e     exp_xcpt;
  brisc_pkg::word_t     exp_store_data;
  logic                 done;
  int                   n_pass;
  int                   n_fail;

  brisc_pkg::word_t     tests [n_rows*n_cols];
  int                   in_issue;
  int                   cycles = 0;

  tb_clock u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  exec_stage UUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .stall         (stall),
    .flush         (flush),
    .issue         (issue),
    .fwd_sel_a     (fwd_sel_a),
    .fwd_sel_b     (fwd_sel_b),
    .alu_res_cache (alu_res_cache),
    .result_wb     (result_wb),
    .ex_out        (ex_out)
  );

  tb_checker #(
    .n_rows (n_rows)
  ) u_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .stall          (stall),
    .flush          (flush),
    .ex_out         (ex_out),
    .row_idx        (row_idx),
    .issue          (issue),
    .exp_valid      (exp_valid),
    .exp_alu_res    (exp_alu_res),
    .exp_pc_src     (exp_pc_src),
    .exp_pc_target  (exp_pc_target),
    .exp_xcpt       (exp_xcpt),
    .exp_store_data (exp_store_data),
    .done           (done),
    .n_pass         (n_pass),
    .n_fail         (n_fail)
  );

  function automatic brisc_pkg::issue_t row_to_issue(input int r);
    brisc_pkg::issue_t i;
    brisc_pkg::word_t  c [n_cols];
    for (int k = 0; k < n_cols; k++) begin
      c[k] = tests[r*n_cols+k];
    end
    i             = '0;
    i.valid       = c[0][0];
    i.pc          = c[1];
    i.rs1_data    = c[2];
    i.rs2_data    = c[3];
    i.imm         = c[4];
    i.rd          = 5'(r);
    i.alu_src1    = brisc_pkg::alu_src1_e'(c[5][0]);
    i.alu_src2    = brisc_pkg::alu_src2_e'(c[6][0]);
    i.alu_ctrl    = brisc_pkg::alu_ctrl_e'(c[7][3:0]);
    i.is_branch   = c[8][0];
    i.branch_cond = brisc_pkg::branch_cond_e'(c[9][2:0]);
    i.is_jump     = c[10][0];
    i.reg_write   = c[0][0] && !c[12][0] && !c[8][0];
    i.result_src  = brisc_pkg::result_src_e'(c[11][1:0]);
    i.mem_write   = c[12][0];
    i.data_size   = brisc_pkg::data_size_e'(c[13][1:0]);
    return i;
  endfunction

  // Forwarding belongs to the row that just entered the issue register
  task automatic drive_forwarding();
    if (flush) begin
      in_issue = -1;
    end else if (!stall) begin
      in_issue = row_idx;
    end
    if (in_issue >= 0) begin
      fwd_sel_a     <= brisc_pkg::fwd_src_e'(tests[in_issue*n_cols+14][1:0]);
      fwd_sel_b     <= brisc_pkg::fwd_src_e'(tests[in_issue*n_cols+15][1:0]);
      alu_res_cache <= tests[in_issue*n_cols+16];
      result_wb     <= tests[in_issue*n_cols+17];
    end else begin
      fwd_sel_a     <= brisc_pkg::fwd_from_rf;
      fwd_sel_b     <= brisc_pkg::fwd_from_rf;
      alu_res_cache <= '0;
      result_wb     <= '0;
    end
  endtask

  task automatic present_row(input int r);
    issue          <= row_to_issue(r);
    stall          <= tests[r*n_cols+18][0];
    flush          <= tests[r*n_cols+19][0];
    row_idx        <= r;
    exp_valid      <= tests[r*n_cols+20][0];
    exp_alu_res    <= tests[r*n_cols+21];
    exp_pc_src     <= tests[r*n_cols+22][0];
    exp_pc_target  <= tests[r*n_cols+23];
    exp_xcpt       <= brisc_pkg::xcpt_e'(tests[r*n_cols+24][1:0]);
    exp_store_data <= tests[r*n_cols+25];
  endtask

  task automatic present_bubble();
    issue   <= '0;
    stall   <= 1'b0;
    flush   <= 1'b0;
    row_idx <= -1;
  endtask

  initial begin
    stall          = 1'b0;
    flush          = 1'b0;
    issue          = '0;
    fwd_sel_a      = brisc_pkg::fwd_from_rf;
    fwd_sel_b      = brisc_pkg::fwd_from_rf;
    alu_res_cache  = '0;
    result_wb      = '0;
    row_idx        = -1;
    in_issue       = -1;
    exp_valid      = 1'b0;
    exp_alu_res    = '0;
    exp_pc_src     = 1'b0;
    exp_pc_target  = '0;
    exp_xcpt       = brisc_pkg::no_xcpt;
    exp_store_data = '0;
    $readmemh("verif/exec_tests.txt", tests);
    @(posedge arst_n);
    for (int r = 0; !done; r++) begin
      @(posedge clk);
      drive_forwarding();
      if (r < n_rows) begin
        present_row(r);
      end else begin
        present_bubble();
      end
    end
    $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    if (arst_n) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
        $display("timeout: DUT did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
      end
    end
  end

endmodule

/* list.f */
logic/brisc_pkg.sv
logic/ex_issue_reg.sv
logic/alu.sv
logic/branch_unit.sv
logic/ex_commit.sv
logic/exec_stage.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

/* verif/exec_tests.txt */
// v pc rs1 rs2 imm src1 src2 ctrl br cond jmp rsrc mw size fwda fwdb cache wb stall flush
// then expected: valid alu_res pc_src pc_target xcpt store_data
1 100 5 7 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 1 c 0 100 0 7
1 104 a b 3 0 1 1 1 0 0 0 0 2 0 0 0 0 0 0 1 7 0 107 0 b
1 108 f0f0 ff00 20 0 0 2 1 1 0 0 0 2 0 0 0 0 0 0 1 f000 1 128 0 ff00
1 10c f0 0 f 0 1 3 0 0 0 0 0 2 0 0 0 0 0 0 1 ff 0 11b 0 0
1 110 1 2 0 0 0 4 0 0 0 0 0 2 1 2 ff f0f 0 0 1 ff0 0 110 0 f0f
1 114 1 1 24 0 1 5 1 3 0 0 0 2 0 0 0 0 0 0 1 10 1 138 0 1
1 118 80000000 1f 8 0 0 6 1 5 0 0 0 2 0 0 0 0 0 0 1 1 1 120 0 1f
1 11c 80000000 4 8 0 0 7 1 3 0 0 0 2 0 0 0 0 0 0 1 f8000000 0 124 0 4
1 120 ffffffff 1 fffffff8 0 0 8 1 2 0 0 0 2 0 0 0 0 0 0 1 1 1 118 0 1
1 124 ffffffff 1 fffffff8 0 0 9 1 4 0 0 0 2 0 0 0 0 0 0 1 0 0 11c 0 1
1 128 0 0 12345 0 1 a 0 0 0 0 0 2 0 0 0 0 0 0 1 12345 0 1246d 0 0
1 12c 5 5 40 0 0 1 1 0 0 0 0 2 0 0 0 0 0 0 1 0 1 16c 0 5
1 130 0 0 20 1 1 0 0 0 1 2 0 2 0 0 0 0 0 0 1 150 1 150 0 0
0 134 0 0 0 0 0 0 0 0 1 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0
1 138 1000 0 2 0 1 0 0 0 0 1 0 2 0 0 0 0 0 0 1 1002 0 13a 1 0
1 13c 1001 abcd 0 0 1 0 0 0 0 0 1 1 0 0 0 0 0 0 1 1001 0 13c 1 abcd
1 140 2002 12 0 0 1 0 0 0 0 0 1 2 0 1 77 0 0 0 1 2002 0 140 1 77
1 144 800 0 4 0 1 0 0 0 0 1 0 2 0 0 0 0 0 0 1 804 0 148 2 0
1 148 ffe 0 0 0 1 0 0 0 0 0 1 1 0 0 0 0 0 0 1 ffe 0 148 2 0
1 14c 1000 0 2 0 1 0 0 0 0 0 0 2 0 0 0 0 0 0 1 1002 0 14e 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0
1 150 1 1 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 1 0 0 0 0 0 0
1 158 2 3 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 1 5 0 158 0 3
